// File: vlog.f
hw/core_pkg.sv
hw/branch_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/core_top.sv
verif/tb_clock.sv
verif/tb_core.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_core -f vlog.f -o tb_core \
    && ./obj_dir/tb_core | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/tb_core.sv
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

    logic      clk;
    logic      rst;
    logic      inst_valid;
    word_t     inst;
    word_t     inst_pc;
    logic      br_taken;
    word_t     br_target;
    logic      wb_valid;
    reg_addr_t wb_addr;
    word_t     wb_data;

    int        seed;
    word_t     pc_now;

    // reference model state
    word_t     model_regs [32];
    int        cyc = 0;
    int        due_q [$];
    reg_addr_t addr_q [$];
    word_t     data_q [$];
    int        wb_seen = 0;
    int        br_seen = 0;

    // expected DUT outputs for the current cycle
    logic      armed = 1'b0;
    logic      exp_wb_valid = 1'b0;
    reg_addr_t exp_wb_addr = '0;
    word_t     exp_wb_data = '0;
    logic      exp_br_taken = 1'b0;
    word_t     exp_br_target = '0;

    logic [5:0] alu_fn [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_AND,
                                FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA, FN_SLLV,
                                FN_SRLV, FN_SRAV};
    logic [5:0] imm_op [8]  = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                OP_XORI, OP_LUI};
    logic [5:0] br_op [4]   = '{OP_BEQ, OP_BNE, OP_J, OP_JAL};

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    core_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    task automatic stop_failed(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // ****************************************
    // instruction encoders
    // ****************************************
    function automatic word_t special_inst(input logic [5:0] fn, input reg_addr_t rd,
                                           input reg_addr_t rs, input reg_addr_t rt,
                                           input logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t imm_inst(input logic [5:0] op, input reg_addr_t rt,
                                       input reg_addr_t rs, input logic [15:0] im);
        return {op, rs, rt, im};
    endfunction

    function automatic word_t jump_inst(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    // ****************************************
    // ISA reference model
    // ****************************************
    task automatic evaluate(input word_t w, input word_t pc, output logic wr,
                            output reg_addr_t dst, output word_t res, output logic tk,
                            output word_t tgt);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [15:0] im;
        word_t       a;
        word_t       b;
        word_t       simm;
        word_t       npc;
        op   = w[31:26];
        fn   = w[5:0];
        sa   = w[10:6];
        im   = w[15:0];
        a    = model_regs[w[25:21]];
        b    = model_regs[w[20:16]];
        simm = {{16{im[15]}}, im};
        npc  = pc + 32'd4;
        // immediate forms write rt by default
        wr   = 1'b1;
        dst  = w[20:16];
        res  = '0;
        tk   = 1'b0;
        tgt  = '0;
        case (op)
            OP_SPECIAL: begin
                dst = w[15:11];
                case (fn)
                    FN_ADD, FN_ADDU: res = a + b;
                    FN_SUB, FN_SUBU: res = a - b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLL:  res = b << sa;
                    FN_SRL:  res = b >> sa;
                    FN_SRA:  res = $signed(b) >>> sa;
                    FN_SLLV: res = b << a[4:0];
                    FN_SRLV: res = b >> a[4:0];
                    FN_SRAV: res = $signed(b) >>> a[4:0];
                    FN_JR: begin
                        wr  = 1'b0;
                        tk  = 1'b1;
                        tgt = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU: res = a + simm;
            OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            OP_SLTIU: res = (a < simm) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & {16'd0, im};
            OP_ORI:   res = a | {16'd0, im};
            OP_XORI:  res = a ^ {16'd0, im};
            OP_LUI:   res = {im, 16'd0};
            OP_BEQ, OP_BNE: begin
                wr  = 1'b0;
                tk  = (op == OP_BEQ) ? (a == b) : (a != b);
                tgt = npc + {simm[29:0], 2'b00};
            end
            // jal links the address after the delay slot
            OP_J, OP_JAL: begin
                wr  = (op == OP_JAL);
                dst = 5'd31;
                res = pc + 32'd8;
                tk  = 1'b1;
                tgt = {npc[31:28], w[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
    endtask

    // one instruction per edge, applied in order, write-back due two edges later
    always @(posedge clk) begin : model_step
        logic      wr;
        reg_addr_t dst;
        word_t     res;
        logic      tk;
        word_t     tgt;
        cyc = cyc + 1;
        tk  = 1'b0;
        tgt = '0;
        if (rst) begin
            armed <= 1'b1;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            due_q.delete();
            addr_q.delete();
            data_q.delete();
            exp_wb_valid <= 1'b0;
            exp_br_taken <= 1'b0;
        end else begin
            if (inst_valid) begin
                evaluate(inst, inst_pc, wr, dst, res, tk, tgt);
                if (wr && dst != 5'd0) begin
                    model_regs[dst] = res;
                    due_q.push_back(cyc + 2);
                    addr_q.push_back(dst);
                    data_q.push_back(res);
                end
                if (tk) begin
                    br_seen++;
                end
            end
            exp_br_taken  <= tk;
            exp_br_target <= tgt;
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                exp_wb_valid <= 1'b1;
                exp_wb_addr  <= addr_q[0];
                exp_wb_data  <= data_q[0];
                void'(due_q.pop_front());
                void'(addr_q.pop_front());
                void'(data_q.pop_front());
                wb_seen++;
            end else begin
                exp_wb_valid <= 1'b0;
            end
        end
    end

    // ****************************************
    // output checks
    // ****************************************
    wb_valid_check: assert property (@(posedge clk) (!armed || wb_valid == exp_wb_valid))
        else stop_failed($sformatf("ERROR at %0t ns: wb_valid is %0b, expected %0b",
                                   $time, $sampled(wb_valid), $sampled(exp_wb_valid)));

    wb_payload_check: assert property (@(posedge clk)
        (!armed || !exp_wb_valid || (wb_addr == exp_wb_addr && wb_data == exp_wb_data)))
        else stop_failed($sformatf("ERROR at %0t ns: write-back r%0d=%h, expected r%0d=%h",
                                   $time, $sampled(wb_addr), $sampled(wb_data),
                                   $sampled(exp_wb_addr), $sampled(exp_wb_data)));

    br_taken_check: assert property (@(posedge clk) (!armed || br_taken == exp_br_taken))
        else stop_failed($sformatf("ERROR at %0t ns: br_taken is %0b, expected %0b",
                                   $time, $sampled(br_taken), $sampled(exp_br_taken)));

    // target only matters when the branch is taken
    br_target_check: assert property (@(posedge clk)
        (!armed || !exp_br_taken || br_target == exp_br_target))
        else stop_failed($sformatf("ERROR at %0t ns: br_target is %h, expected %h",
                                   $time, $sampled(br_target), $sampled(exp_br_target)));

    // ****************************************
    // stimulus
    // ****************************************
    task automatic issue(input word_t w);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        inst_pc    <= pc_now;
        pc_now      = pc_now + 32'd4;
    endtask

    // bubbles carry garbage that must be ignored
    task automatic idle(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            inst_valid <= 1'b0;
            inst       <= $random(seed);
        end
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                stop_failed("reset was never released");
            end
        end
    endtask

    // model queue and last expected write-back both settled
    task automatic wait_for_drain();
        int n;
        n = 0;
        @(negedge clk);
        while (due_q.size() != 0 || exp_wb_valid) begin
            @(negedge clk);
            n++;
            if (n > 10) begin
                stop_failed("expected write-backs were still pending at the end of the test");
            end
        end
    endtask

    initial begin
        word_t     rnd;
        reg_addr_t rs_r;
        reg_addr_t rt_r;
        reg_addr_t rd_r;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        seed       = 32'hf124_915a;
        pc_now     = 32'hb040_0000;
        wait_for_reset();

        // operand registers
        issue(imm_inst(OP_ADDIU, 5'd1, 5'd0, 16'h8123));
        issue(imm_inst(OP_ORI, 5'd2, 5'd0, 16'h00f5));
        issue(imm_inst(OP_LUI, 5'd3, 5'd0, 16'h9ff0));
        idle(3);

        // register forms, sources never overwritten here
        for (int i = 0; i < 16; i++) begin
            issue(special_inst(alu_fn[i], 5'(i + 10), 5'd2, 5'd1, 5'(i + 1)));
            issue(special_inst(alu_fn[i], 5'(i + 10), 5'd3, 5'd2, 5'd31));
        end
        // immediate forms, both immediate signs
        for (int i = 0; i < 8; i++) begin
            issue(imm_inst(imm_op[i], 5'(i + 24), 5'd1, 16'h8a5c));
            issue(imm_inst(imm_op[i], 5'(i + 24), 5'd3, 16'h0013));
        end
        idle(3);

        // dependency distance gap+1, last pass reads the register file
        for (int gap = 0; gap < 4; gap++) begin
            issue(imm_inst(OP_ADDIU, 5'd4, 5'd0, 16'(gap + 17)));
            idle(gap);
            issue(special_inst(FN_ADDU, 5'd4, 5'd4, 5'd4, 5'd0));
            idle(gap);
            issue(special_inst(FN_SUBU, 5'd5, 5'd4, 5'd1, 5'd0));
            issue(special_inst(FN_XOR, 5'd6, 5'd5, 5'd4, 5'd0));
        end

        // r0 as destination, then as source
        issue(imm_inst(OP_ADDIU, 5'd0, 5'd1, 16'h1234));
        issue(special_inst(FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
        issue(special_inst(FN_OR, 5'd7, 5'd0, 5'd2, 5'd0));
        issue(imm_inst(OP_ADDIU, 5'd9, 5'd0, 16'h0001));
        idle(2);

        // branches on forwarded operands
        issue(special_inst(FN_ADDU, 5'd8, 5'd1, 5'd0, 5'd0));
        issue(imm_inst(OP_BEQ, 5'd1, 5'd8, 16'h0010));
        issue(imm_inst(OP_BEQ, 5'd2, 5'd8, 16'hfff8));
        issue(imm_inst(OP_BNE, 5'd2, 5'd8, 16'hff00));
        issue(imm_inst(OP_BNE, 5'd1, 5'd8, 16'h0004));
        issue(jump_inst(OP_J, 26'h123_4567));
        issue(jump_inst(OP_JAL, 26'h2a5_5a5a));
        // link value still in execute
        issue(special_inst(FN_JR, 5'd0, 5'd31, 5'd0, 5'd0));
        idle(2);
        issue(special_inst(FN_JR, 5'd0, 5'd2, 5'd0, 5'd0));

        // seeded mix on r0..r7 for dense dependencies
        for (int n = 0; n < 400; n++) begin
            rnd  = $random(seed);
            rs_r = {2'b00, rnd[10:8]};
            rt_r = {2'b00, rnd[13:11]};
            rd_r = {2'b00, rnd[16:14]};
            case (rnd[2:0])
                3'd0: idle(1);
                3'd1: begin
                    // codes outside the kept set
                    case (rnd[4:3])
                        2'd0: issue({6'h23, rnd[25:0]});
                        2'd1: issue({6'h2b, rnd[25:0]});
                        2'd2: issue(special_inst(6'h18, rd_r, rs_r, rt_r, 5'd0));
                        default: issue(special_inst(6'h09, rd_r, rs_r, rt_r, 5'd0));
                    endcase
                end
                3'd2, 3'd3, 3'd4: issue(special_inst(alu_fn[rnd[26:23]], rd_r, rs_r, rt_r,
                                                     rnd[21:17]));
                3'd5: issue(imm_inst(imm_op[rnd[25:23]], rt_r, rs_r, rnd[31:16]));
                3'd6: issue(imm_inst(br_op[rnd[24:23]], rt_r, rs_r, rnd[31:16]));
                default: issue(special_inst(FN_JR, 5'd0, rs_r, 5'd0, 5'd0));
            endcase
        end

        idle(1);
        wait_for_drain();
        idle(2);

        if (wb_seen > 0 && br_seen > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_failed("no write-back or taken branch was ever checked");
        end
    end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        rst = 1'b1;
    end

    always #50 clk = ~clk;

    // reset held over the first two rising edges
    initial begin
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: hw/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      inst_valid,
    input  word_t     inst,
    input  word_t     inst_pc,
    output logic      br_taken,
    output word_t     br_target,
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    // ****************************************
    // decode to execute
    // ****************************************
    logic        ex_valid_in;
    word_t       pc;
    alu_op_e     alu_op;
    src_a_e      src_a;
    src_b_e      src_b;
    word_t       rs_value;
    word_t       rt_value;
    logic [15:0] imm;
    logic [4:0]  shamt;
    reg_addr_t   dest;
    logic        dest_we;

    // execute to result, also forwarded to decode
    logic        ex_valid;
    logic        ex_we;
    reg_addr_t   ex_dest;
    word_t       ex_result;

    // register file read ports
    reg_addr_t   rf_raddr1;
    reg_addr_t   rf_raddr2;
    word_t       rf_rdata1;
    word_t       rf_rdata2;

    decode_stage u_decode (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .ex_valid    (ex_valid),
        .ex_we       (ex_we),
        .ex_dest     (ex_dest),
        .ex_result   (ex_result),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .ex_valid_in (ex_valid_in),
        .pc          (pc),
        .alu_op      (alu_op),
        .src_a       (src_a),
        .src_b       (src_b),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .imm         (imm),
        .shamt       (shamt),
        .dest        (dest),
        .dest_we     (dest_we)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst         (rst),
        .ex_valid_in (ex_valid_in),
        .pc          (pc),
        .alu_op      (alu_op),
        .src_a       (src_a),
        .src_b       (src_b),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .imm         (imm),
        .shamt       (shamt),
        .dest        (dest),
        .dest_we     (dest_we),
        .ex_valid    (ex_valid),
        .ex_we       (ex_we),
        .ex_dest     (ex_dest),
        .ex_result   (ex_result)
    );

    result_stage u_result (
        .clk       (clk),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .ex_we     (ex_we),
        .ex_dest   (ex_dest),
        .ex_result (ex_result),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2)
    );

endmodule

// File: hw/result_stage.sv
`timescale 1ns/1ps

module result_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ex_valid,
    input  logic      ex_we,
    input  reg_addr_t ex_dest,
    input  word_t     ex_result,
    input  reg_addr_t rf_raddr1,
    input  reg_addr_t rf_raddr2,
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output word_t     rf_rdata1,
    output word_t     rf_rdata2
);

    // result register
    // only valid writing instructions raise wb_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_addr  <= '0;
            wb_data  <= '0;
        end else begin
            wb_valid <= ex_valid && ex_we;
            wb_addr  <= ex_dest;
            wb_data  <= ex_result;
        end
    end

    // write happens at the end of the write-back cycle
    reg_file u_regs (
        .clk    (clk),
        .rst    (rst),
        .we     (wb_valid),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ex_valid_in,
    input  word_t       pc,
    input  alu_op_e     alu_op,
    input  src_a_e      src_a,
    input  src_b_e      src_b,
    input  word_t       rs_value,
    input  word_t       rt_value,
    input  logic [15:0] imm,
    input  logic [4:0]  shamt,
    input  reg_addr_t   dest,
    input  logic        dest_we,
    output logic        ex_valid,
    output logic        ex_we,
    output reg_addr_t   ex_dest,
    output word_t       ex_result
);

    // ****************************************
    // execute register
    // ****************************************
    word_t       x_pc;
    alu_op_e     x_op;
    src_a_e      x_src_a;
    src_b_e      x_src_b;
    word_t       x_rs;
    word_t       x_rt;
    logic [15:0] x_imm;
    logic [4:0]  x_shamt;

    word_t       op_a;
    word_t       op_b;
    logic [4:0]  sh;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
            ex_dest  <= '0;
            x_pc     <= '0;
            x_op     <= ALU_ADD;
            x_src_a  <= SRC_A_RS;
            x_src_b  <= SRC_B_RT;
            x_rs     <= '0;
            x_rt     <= '0;
            x_imm    <= '0;
            x_shamt  <= '0;
        end else begin
            ex_valid <= ex_valid_in;
            ex_we    <= dest_we;
            ex_dest  <= dest;
            x_pc     <= pc;
            x_op     <= alu_op;
            x_src_a  <= src_a;
            x_src_b  <= src_b;
            x_rs     <= rs_value;
            x_rt     <= rt_value;
            x_imm    <= imm;
            x_shamt  <= shamt;
        end
    end

    // operand select
    always_comb begin
        case (x_src_a)
            SRC_A_SHAMT: op_a = {27'd0, x_shamt};
            SRC_A_PC:    op_a = x_pc;
            default:     op_a = x_rs;
        endcase
        case (x_src_b)
            SRC_B_SIMM:  op_b = {{16{x_imm[15]}}, x_imm};
            SRC_B_ZIMM:  op_b = {16'd0, x_imm};
            SRC_B_EIGHT: op_b = 32'd8;
            default:     op_b = x_rt;
        endcase
    end

    // shift amount, low five bits only
    assign sh = op_a[4:0];

    // ****************************************
    // alu
    // ****************************************
    always_comb begin
        case (x_op)
            // wraps, no overflow trap
            ALU_ADD:  ex_result = op_a + op_b;
            ALU_SUB:  ex_result = op_a - op_b;
            ALU_SLT:  ex_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: ex_result = {31'd0, op_a < op_b};
            ALU_AND:  ex_result = op_a & op_b;
            ALU_OR:   ex_result = op_a | op_b;
            ALU_XOR:  ex_result = op_a ^ op_b;
            ALU_NOR:  ex_result = ~(op_a | op_b);
            ALU_SLL:  ex_result = op_b << sh;
            ALU_SRL:  ex_result = op_b >> sh;
            ALU_SRA:  ex_result = $signed(op_b) >>> sh;
            ALU_LUI:  ex_result = {op_b[15:0], 16'd0};
            default:  ex_result = '0;
        endcase
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      inst_valid,
    input  word_t     inst,
    input  word_t     inst_pc,
    input  logic      ex_valid,
    input  logic      ex_we,
    input  reg_addr_t ex_dest,
    input  word_t     ex_result,
    input  logic      wb_valid,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    output logic      br_taken,
    output word_t     br_target,
    output logic      ex_valid_in,
    output word_t     pc,
    output alu_op_e   alu_op,
    output src_a_e    src_a,
    output src_b_e    src_b,
    output word_t     rs_value,
    output word_t     rt_value,
    output logic [15:0] imm,
    output logic [4:0]  shamt,
    output reg_addr_t dest,
    output logic      dest_we
);

    logic        dec_valid;
    word_t       dec_inst;
    word_t       dec_pc;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [25:0] instr_index;

    // set when the decoded instruction writes a register
    logic        writes;

    // decode register, one slot, no hold
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            dec_inst  <= '0;
            dec_pc    <= '0;
        end else begin
            dec_valid <= inst_valid;
            dec_inst  <= inst;
            dec_pc    <= inst_pc;
        end
    end

    // ****************************************
    // field split
    // ****************************************
    assign opcode      = dec_inst[OPC_LSB +: 6];
    assign rs          = dec_inst[RS_LSB +: 5];
    assign rt          = dec_inst[RT_LSB +: 5];
    assign rd          = dec_inst[RD_LSB +: 5];
    assign shamt       = dec_inst[SA_LSB +: 5];
    assign funct       = dec_inst[5:0];
    assign imm         = dec_inst[15:0];
    assign instr_index = dec_inst[25:0];

    assign pc          = dec_pc;
    assign ex_valid_in = dec_valid;

    // ****************************************
    // instruction decode
    // ****************************************
    always_comb begin
        alu_op = ALU_ADD;
        src_a  = SRC_A_RS;
        src_b  = SRC_B_RT;
        dest   = rd;
        writes = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                writes = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLLV: alu_op = ALU_SLL;
                    FN_SRLV: alu_op = ALU_SRL;
                    FN_SRAV: alu_op = ALU_SRA;
                    // fixed shifts take the amount from the sa field
                    FN_SLL, FN_SRL, FN_SRA: begin
                        src_a  = SRC_A_SHAMT;
                        alu_op = (funct == FN_SLL) ? ALU_SLL :
                                 (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    // jr and unknown codes write nothing
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                writes = 1'b1;
                dest   = rt;
                src_b  = SRC_B_SIMM;
                alu_op = (opcode == OP_SLTI)  ? ALU_SLT :
                         (opcode == OP_SLTIU) ? ALU_SLTU : ALU_ADD;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                writes = 1'b1;
                dest   = rt;
                src_b  = SRC_B_ZIMM;
                alu_op = (opcode == OP_ANDI) ? ALU_AND :
                         (opcode == OP_ORI)  ? ALU_OR  :
                         (opcode == OP_XORI) ? ALU_XOR : ALU_LUI;
            end
            // link value pc+8 goes through the adder
            OP_JAL: begin
                writes = 1'b1;
                dest   = LINK_REG;
                src_a  = SRC_A_PC;
                src_b  = SRC_B_EIGHT;
            end
            default: writes = 1'b0;
        endcase
    end

    // r0 writes are dropped here, not in the register file
    assign dest_we = dec_valid && writes && (dest != '0);

    // ****************************************
    // operand read and forwarding
    // ****************************************
    assign rf_raddr1 = rs;
    assign rf_raddr2 = rt;

    // execute first, then result, then register file
    assign rs_value = (ex_valid && ex_we && rs != '0 && ex_dest == rs) ? ex_result :
                      (wb_valid && rs != '0 && wb_addr == rs) ? wb_data : rf_rdata1;
    assign rt_value = (ex_valid && ex_we && rt != '0 && ex_dest == rt) ? ex_result :
                      (wb_valid && rt != '0 && wb_addr == rt) ? wb_data : rf_rdata2;

    // branches resolve here, one cycle after the instruction is offered
    branch_unit u_branch (
        .valid       (dec_valid),
        .pc          (dec_pc),
        .opcode      (opcode),
        .funct       (funct),
        .imm         (imm),
        .instr_index (instr_index),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .taken       (br_taken),
        .target      (br_target)
    );

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    // 32 general purpose registers
    word_t regs [32];

    // cleared on reset, one write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass here, decode handles same-cycle writes
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import core_pkg::*; (
    input  logic        valid,
    input  word_t       pc,
    input  logic [5:0]  opcode,
    input  logic [5:0]  funct,
    input  logic [15:0] imm,
    input  logic [25:0] instr_index,
    input  word_t       rs_value,
    input  word_t       rt_value,
    output logic        taken,
    output word_t       target
);

    word_t pc_plus4;
    word_t rel_target;
    word_t abs_target;
    logic  equal;

    assign pc_plus4 = pc + 32'd4;

    // word offset, sign extended
    assign rel_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};

    // stays inside the current 256 MB region
    assign abs_target = {pc_plus4[31:28], instr_index, 2'b00};

    // compare on forwarded operands
    assign equal = (rs_value == rt_value);

    always_comb begin
        taken  = 1'b0;
        target = '0;
        if (valid) begin
            case (opcode)
                OP_BEQ: begin
                    taken  = equal;
                    target = rel_target;
                end
                OP_BNE: begin
                    taken  = !equal;
                    target = rel_target;
                end
                OP_J, OP_JAL: begin
                    taken  = 1'b1;
                    target = abs_target;
                end
                OP_SPECIAL: begin
                    // jr only
                    taken  = (funct == FN_JR);
                    target = (funct == FN_JR) ? rs_value : '0;
                end
                default: taken = 1'b0;
            endcase
        end
    end

endmodule

// File: hw/core_pkg.sv
package core_pkg;

    // ****************************************
    // basic word types
    // ****************************************
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // jal link destination
    localparam reg_addr_t LINK_REG = 5'd31;

    // low bit of each instruction field
    localparam int OPC_LSB = 26;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;
    localparam int SA_LSB  = 6;

    // ****************************************
    // major opcodes
    // ****************************************
    localparam logic [5:0] OP_SPECIAL = 6'b00_0000;
    localparam logic [5:0] OP_J       = 6'b00_0010;
    localparam logic [5:0] OP_JAL     = 6'b00_0011;
    localparam logic [5:0] OP_BEQ     = 6'b00_0100;
    localparam logic [5:0] OP_BNE     = 6'b00_0101;
    localparam logic [5:0] OP_ADDI    = 6'b00_1000;
    localparam logic [5:0] OP_ADDIU   = 6'b00_1001;
    localparam logic [5:0] OP_SLTI    = 6'b00_1010;
    localparam logic [5:0] OP_SLTIU   = 6'b00_1011;
    localparam logic [5:0] OP_ANDI    = 6'b00_1100;
    localparam logic [5:0] OP_ORI     = 6'b00_1101;
    localparam logic [5:0] OP_XORI    = 6'b00_1110;
    localparam logic [5:0] OP_LUI     = 6'b00_1111;

    // ****************************************
    // SPECIAL function codes
    // ****************************************
    localparam logic [5:0] FN_SLL  = 6'b00_0000;
    localparam logic [5:0] FN_SRL  = 6'b00_0010;
    localparam logic [5:0] FN_SRA  = 6'b00_0011;
    localparam logic [5:0] FN_SLLV = 6'b00_0100;
    localparam logic [5:0] FN_SRLV = 6'b00_0110;
    localparam logic [5:0] FN_SRAV = 6'b00_0111;
    localparam logic [5:0] FN_JR   = 6'b00_1000;
    localparam logic [5:0] FN_ADD  = 6'b10_0000;
    localparam logic [5:0] FN_ADDU = 6'b10_0001;
    localparam logic [5:0] FN_SUB  = 6'b10_0010;
    localparam logic [5:0] FN_SUBU = 6'b10_0011;
    localparam logic [5:0] FN_AND  = 6'b10_0100;
    localparam logic [5:0] FN_OR   = 6'b10_0101;
    localparam logic [5:0] FN_XOR  = 6'b10_0110;
    localparam logic [5:0] FN_NOR  = 6'b10_0111;
    localparam logic [5:0] FN_SLT  = 6'b10_1010;
    localparam logic [5:0] FN_SLTU = 6'b10_1011;

    // alu operations, shared by decode and execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // operand a source
    typedef enum logic [1:0] {
        SRC_A_RS,
        SRC_A_SHAMT,
        SRC_A_PC
    } src_a_e;

    // operand b source
    typedef enum logic [1:0] {
        SRC_B_RT,
        SRC_B_SIMM,
        SRC_B_ZIMM,
        SRC_B_EIGHT
    } src_b_e;

endpackage
